// File: files.f
hw/cache_geom_pkg.sv
hw/mem_bus_pkg.sv
hw/sram_1rw.sv
hw/tag_store.sv
hw/data_store.sv
hw/cache_ctrl.sv
hw/cache_top.sv
test/cache_checker.sv
test/cache_tb.sv

// File: hw/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl (
    input  logic                                        clk,
    input  logic                                        resetn,
    // cpu side
    input  logic                                        valid,
    input  logic                                        op,      // 1 write, 0 read
    input  cache_geom_pkg::cache_addr_t                 addr,
    input  logic [cache_geom_pkg::WORD_W/8-1:0]          wstrb,
    input  logic [cache_geom_pkg::WORD_W-1:0]            wdata,
    output logic                                        addr_ok,
    output logic                                        data_ok,
    // tag store results
    input  logic                                        hit,
    input  logic                                        victim_valid,
    input  logic                                        victim_dirty,
    input  logic [cache_geom_pkg::TAG_W-1:0]             victim_tag,
    // array control
    output logic                                        lookup,
    output logic [cache_geom_pkg::INDEX_W-1:0]           rd_index,
    output logic [cache_geom_pkg::INDEX_W-1:0]           req_index,
    output logic [cache_geom_pkg::TAG_W-1:0]             req_tag,
    output logic [$clog2(cache_geom_pkg::NUM_BANKS)-1:0] bank_sel,
    output logic [cache_geom_pkg::WORD_W/8-1:0]          req_wstrb,
    output logic [cache_geom_pkg::WORD_W-1:0]            req_wdata,
    output logic                                        wr_hit,
    output logic                                        fill_we,
    output logic                                        refill_beat,
    output logic [mem_bus_pkg::BEAT_CNT_W-1:0]           beat_cnt,
    output logic                                        merge_beat,
    output logic                                        mark_dirty,
    output logic                                        clear_dirty,
    output logic                                        refill_done,
    // memory side
    output logic                                        rd_req,
    output logic [31:0]                                 rd_addr,
    output logic                                        wr_req,
    output logic [31:0]                                 wr_addr,
    input  logic                                        rd_rdy,
    input  logic                                        wr_rdy,
    input  logic                                        ret_valid,
    input  logic                                        ret_last
);

    import cache_geom_pkg::*;
    import mem_bus_pkg::*;

    localparam logic [4:0] IDLE    = 5'b00001;
    localparam logic [4:0] LOOKUP  = 5'b00010;
    localparam logic [4:0] MISS    = 5'b00100;
    localparam logic [4:0] REPLACE = 5'b01000;
    localparam logic [4:0] REFILL  = 5'b10000;

    logic [4:0]  state;
    logic [4:0]  state_nxt;
    cache_addr_t req_addr;
    cache_addr_t rd_line;
    cache_addr_t wr_line;
    logic        req_op;
    logic        need_wb;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign need_wb = victim_valid & victim_dirty;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (valid) state_nxt = LOOKUP;
            LOOKUP:  state_nxt = hit ? IDLE : MISS;
            MISS:    if (!need_wb || wr_rdy) state_nxt = REPLACE;  // clean victim skips
            REPLACE: if (rd_rdy) state_nxt = REFILL;
            REFILL:  if (ret_valid && ret_last) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    // request buffer
    always_ff @(posedge clk) begin
        if (valid && addr_ok) begin
            req_op    <= op;
            req_addr  <= addr;
            req_wstrb <= wstrb;
            req_wdata <= wdata;
        end
    end

    assign req_index = req_addr.fields.index;
    assign req_tag   = req_addr.fields.tag;
    assign bank_sel  = req_addr.fields.bank;
    assign rd_index  = (state == IDLE) ? addr.fields.index : req_index;  // arrays read a cycle early

    always_ff @(posedge clk) begin
        if (!resetn) begin
            beat_cnt <= '0;
        end else if (refill_beat) begin
            beat_cnt <= ret_last ? '0 : beat_cnt + 1'b1;
        end
    end

    assign lookup      = (state == LOOKUP);
    assign wr_hit      = lookup & hit & req_op;
    assign refill_beat = (state == REFILL) & ret_valid;
    assign refill_done = refill_beat & ret_last;
    assign fill_we     = refill_done;               // tag and valid land with the last beat
    assign merge_beat  = refill_beat & req_op & (beat_cnt == bank_sel);
    assign mark_dirty  = wr_hit | (refill_done & req_op);
    assign clear_dirty = refill_done & ~req_op;

    assign addr_ok = (state == IDLE);
    assign data_ok = (lookup & hit)
                   | (refill_beat & ~req_op & (beat_cnt == bank_sel))  // critical word
                   | (refill_done & req_op);

    // line aligned addresses
    always_comb begin
        rd_line.fields.tag      = req_tag;
        rd_line.fields.index    = req_index;
        rd_line.fields.bank     = '0;
        rd_line.fields.byte_sel = '0;
        wr_line                 = rd_line;
        wr_line.fields.tag      = victim_tag;
    end

    assign rd_req  = (state == REPLACE);
    assign rd_addr = rd_line.raw;
    assign wr_req  = (state == MISS) & need_wb & wr_rdy;  // single pulse as MISS exits
    assign wr_addr = wr_line.raw;

    a_req_excl: assert property (@(posedge clk) disable iff (!resetn)
        !(rd_req && wr_req));

    a_no_ok_idle: assert property (@(posedge clk) disable iff (!resetn)
        (state == IDLE) |-> !data_ok);

    // memory must close the burst after exactly one line of beats
    a_burst_len: assert property (@(posedge clk) disable iff (!resetn)
        refill_done |-> (beat_cnt == BEAT_CNT_W'(BEATS_PER_LINE - 1)));

endmodule

// File: hw/cache_geom_pkg.sv
package cache_geom_pkg;

    localparam int NUM_WAYS  = 2;
    localparam int NUM_SETS  = 256;
    localparam int INDEX_W   = 8;
    localparam int TAG_W     = 20;
    localparam int OFFSET_W  = 4;
    localparam int NUM_BANKS = 4;   // 32-bit words per line
    localparam int WORD_W    = 32;

    // offset is split into bank select and byte select
    typedef struct packed {
        logic [TAG_W-1:0]                        tag;
        logic [INDEX_W-1:0]                      index;
        logic [$clog2(NUM_BANKS)-1:0]            bank;
        logic [OFFSET_W-$clog2(NUM_BANKS)-1:0]   byte_sel;
    } cache_addr_fields_t;

    // one address word, read flat or as cache fields
    typedef union packed {
        logic [TAG_W+INDEX_W+OFFSET_W-1:0] raw;
        cache_addr_fields_t                fields;
    } cache_addr_t;

endpackage

// File: hw/cache_top.sv
`timescale 1ns/1ps

module cache_top (
    input  logic                                clk,
    input  logic                                resetn,
    // cpu side
    input  logic                                valid,
    input  logic                                op,
    input  cache_geom_pkg::cache_addr_t         addr,
    input  logic [cache_geom_pkg::WORD_W/8-1:0]  wstrb,
    input  logic [cache_geom_pkg::WORD_W-1:0]    wdata,
    output logic                                addr_ok,
    output logic                                data_ok,
    output logic [cache_geom_pkg::WORD_W-1:0]    rdata,
    // memory side
    output logic                                rd_req,
    output logic [31:0]                         rd_addr,
    input  logic                                rd_rdy,
    input  logic                                ret_valid,
    input  logic                                ret_last,
    input  logic [cache_geom_pkg::WORD_W-1:0]    ret_data,
    output logic                                wr_req,
    output logic [31:0]                         wr_addr,
    output logic [mem_bus_pkg::LINE_W-1:0]       wr_data,
    input  logic                                wr_rdy
);

    import cache_geom_pkg::*;
    import mem_bus_pkg::*;

    logic                         hit, hit_way;
    logic                         victim_way, victim_valid, victim_dirty;
    logic [TAG_W-1:0]             victim_tag;
    logic                         lookup;
    logic [INDEX_W-1:0]           rd_index, req_index;
    logic [TAG_W-1:0]             req_tag;
    logic [$clog2(NUM_BANKS)-1:0] bank_sel;
    logic [WORD_W/8-1:0]          req_wstrb;
    logic [WORD_W-1:0]            req_wdata;
    logic [WORD_W-1:0]            hit_word;
    logic                         wr_hit, fill_we, refill_beat, merge_beat;
    logic                         mark_dirty, clear_dirty, refill_done;
    logic [BEAT_CNT_W-1:0]        beat_cnt;

    // a read miss forwards the returning beat
    assign rdata = refill_beat ? ret_data : hit_word;

    cache_ctrl u_ctrl (
        .clk, .resetn,
        .valid, .op, .addr, .wstrb, .wdata, .addr_ok, .data_ok,
        .hit, .victim_valid, .victim_dirty, .victim_tag,
        .lookup, .rd_index, .req_index, .req_tag, .bank_sel, .req_wstrb, .req_wdata,
        .wr_hit, .fill_we, .refill_beat, .beat_cnt, .merge_beat,
        .mark_dirty, .clear_dirty, .refill_done,
        .rd_req, .rd_addr, .wr_req, .wr_addr,
        .rd_rdy, .wr_rdy, .ret_valid, .ret_last
    );

    tag_store u_tags (
        .clk, .resetn,
        .rd_index, .req_index, .req_tag,
        .lookup, .fill_we, .mark_dirty, .clear_dirty, .refill_done,
        .hit, .hit_way, .victim_way, .victim_valid, .victim_dirty, .victim_tag
    );

    data_store u_data (
        .clk, .rd_index, .bank_sel,
        .hit_way, .wr_hit, .wstrb(req_wstrb), .wdata(req_wdata),
        .refill_beat, .fill_way(victim_way), .beat_cnt, .ret_data, .merge_beat,
        .hit_word, .victim_line(wr_data),
        .victim_way
    );

endmodule

// File: hw/data_store.sv
`timescale 1ns/1ps

module data_store (
    input  logic                                            clk,
    input  logic [cache_geom_pkg::INDEX_W-1:0]               rd_index,
    input  logic [$clog2(cache_geom_pkg::NUM_BANKS)-1:0]     bank_sel,
    input  logic                                            hit_way,
    input  logic                                            wr_hit,
    input  logic [cache_geom_pkg::WORD_W/8-1:0]              wstrb,
    input  logic [cache_geom_pkg::WORD_W-1:0]                wdata,
    input  logic                                            refill_beat,
    input  logic                                            fill_way,
    input  logic [mem_bus_pkg::BEAT_CNT_W-1:0]               beat_cnt,
    input  logic [cache_geom_pkg::WORD_W-1:0]                ret_data,
    input  logic                                            merge_beat,
    output logic [cache_geom_pkg::WORD_W-1:0]                hit_word,
    output logic [mem_bus_pkg::LINE_W-1:0]                   victim_line,
    input  logic                                            victim_way
);

    import cache_geom_pkg::*;
    import mem_bus_pkg::*;

    logic [WORD_W-1:0] bank_q [NUM_WAYS][NUM_BANKS];
    logic [WORD_W-1:0] merged_word;
    logic [WORD_W-1:0] bank_wdata;

    // buffered store bytes win over the returned line data
    always_comb begin
        for (int i = 0; i < WORD_W / 8; i++) begin
            merged_word[i*8 +: 8] = wstrb[i] ? wdata[i*8 +: 8] : ret_data[i*8 +: 8];
        end
    end

    // one bank written per cycle so one write word serves all
    assign bank_wdata = wr_hit     ? wdata       :
                        merge_beat ? merged_word : ret_data;

    genvar w, b;
    generate
        for (w = 0; w < NUM_WAYS; w++) begin : g_way
            for (b = 0; b < NUM_BANKS; b++) begin : g_bank
                logic [WORD_W/8-1:0] bank_we;

                assign bank_we =
                    (wr_hit && hit_way == w && bank_sel == b)         ? wstrb :
                    (refill_beat && fill_way == w && beat_cnt == b)   ? '1    : '0;

                sram_1rw #(
                    .DEPTH (NUM_SETS),
                    .WIDTH (WORD_W),
                    .BYTES (WORD_W / 8)
                ) u_bank (
                    .clk   (clk),
                    .we    (bank_we),
                    .addr  (rd_index),
                    .wdata (bank_wdata),
                    .rdata (bank_q[w][b])
                );
            end
        end

        for (b = 0; b < NUM_BANKS; b++) begin : g_victim
            assign victim_line[b*WORD_W +: WORD_W] = bank_q[victim_way][b];  // bank 0 lowest
        end
    endgenerate

    assign hit_word = bank_q[hit_way][bank_sel];

endmodule

// File: hw/mem_bus_pkg.sv
package mem_bus_pkg;

    localparam int LINE_W         = 128;   // full line on the write-back bus
    localparam int BEATS_PER_LINE = 4;     // one 32-bit word per refill beat
    localparam int BEAT_CNT_W     = 2;

endpackage

// File: hw/sram_1rw.sv
`timescale 1ns/1ps

module sram_1rw #(
    parameter int DEPTH = 256,
    parameter int WIDTH = 32,
    parameter int BYTES = 4
) (
    input  logic                     clk,
    input  logic [BYTES-1:0]         we,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  logic [WIDTH-1:0]         wdata,
    output logic [WIDTH-1:0]         rdata
);

    localparam int LANE_W = WIDTH / BYTES;

    logic [WIDTH-1:0] mem [DEPTH];

    // registered read returns the old word on a write cycle
    always_ff @(posedge clk) begin
        for (int b = 0; b < BYTES; b++) begin
            if (we[b]) begin
                mem[addr][b*LANE_W +: LANE_W] <= wdata[b*LANE_W +: LANE_W];
            end
        end
        rdata <= mem[addr];
    end

endmodule

// File: hw/tag_store.sv
`timescale 1ns/1ps

module tag_store (
    input  logic                              clk,
    input  logic                              resetn,
    input  logic [cache_geom_pkg::INDEX_W-1:0] rd_index,   // ram read address
    input  logic [cache_geom_pkg::INDEX_W-1:0] req_index,  // buffered request set
    input  logic [cache_geom_pkg::TAG_W-1:0]   req_tag,
    input  logic                              lookup,
    input  logic                              fill_we,
    input  logic                              mark_dirty,
    input  logic                              clear_dirty,
    input  logic                              refill_done,
    output logic                              hit,
    output logic                              hit_way,
    output logic                              victim_way,
    output logic                              victim_valid,
    output logic                              victim_dirty,
    output logic [cache_geom_pkg::TAG_W-1:0]   victim_tag
);

    import cache_geom_pkg::*;

    logic [TAG_W:0]      tagv_q     [NUM_WAYS];  // {tag, valid}
    logic [NUM_SETS-1:0] valid_bits [NUM_WAYS];
    logic [NUM_SETS-1:0] dirty_bits [NUM_WAYS];
    logic [NUM_SETS-1:0] repl_bits;               // names the next victim way
    logic [NUM_WAYS-1:0] valid_q;
    logic [NUM_WAYS-1:0] way_hit;
    logic                upd_way;

    genvar w;
    generate
        for (w = 0; w < NUM_WAYS; w++) begin : g_way
            sram_1rw #(
                .DEPTH (NUM_SETS),
                .WIDTH (TAG_W + 1),
                .BYTES (1)
            ) u_tagv (
                .clk   (clk),
                .we    (fill_we && (victim_way == w)),
                .addr  (rd_index),
                .wdata ({req_tag, 1'b1}),
                .rdata (tagv_q[w])
            );
            // valid flops qualify the ram word until a fill writes it
            assign way_hit[w] = valid_q[w] & tagv_q[w][0] & (tagv_q[w][TAG_W:1] == req_tag);
        end
    endgenerate

    assign hit          = |way_hit;
    assign hit_way      = way_hit[1];
    assign victim_way   = repl_bits[req_index];
    assign victim_valid = valid_q[victim_way] & tagv_q[victim_way][0];
    assign victim_dirty = dirty_bits[victim_way][req_index];
    assign victim_tag   = tagv_q[victim_way][TAG_W:1];
    assign upd_way      = lookup ? hit_way : victim_way;  // write hit or refill way

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_bits <= '{default: '0};
            valid_q    <= '0;
        end else begin
            if (fill_we) begin
                valid_bits[victim_way][req_index] <= 1'b1;
            end
            for (int i = 0; i < NUM_WAYS; i++) begin
                valid_q[i] <= valid_bits[i][rd_index];  // same latency as the ram
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            dirty_bits <= '{default: '0};
        end else if (mark_dirty) begin
            dirty_bits[upd_way][req_index] <= 1'b1;
        end else if (clear_dirty) begin
            dirty_bits[upd_way][req_index] <= 1'b0;
        end
    end

    // two-way lru points away from the way just used
    always_ff @(posedge clk) begin
        if (!resetn) begin
            repl_bits <= '0;
        end else if (lookup && hit) begin
            repl_bits[req_index] <= ~hit_way;
        end else if (refill_done) begin
            repl_bits[req_index] <= ~victim_way;
        end
    end

    a_one_hot_hit: assert property (@(posedge clk) disable iff (!resetn)
        lookup |-> !(&way_hit));

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module cache_tb -f files.f -o cache_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/cache_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
exit 1

// File: test/cache_checker.sv
`timescale 1ns/1ps

module cache_checker (
    input  logic                           clk,
    input  logic                           resetn,
    input  logic                           valid,
    input  logic                           op,
    input  cache_geom_pkg::cache_addr_t    addr,
    input  logic [3:0]                     wstrb,
    input  logic [31:0]                    wdata,
    input  logic [31:0]                    exp_rdata,
    input  logic                           addr_ok,
    input  logic                           data_ok,
    input  logic [31:0]                    rdata,
    input  logic                           rd_req,
    input  logic                           rd_rdy,
    input  logic [31:0]                    rd_addr,
    input  logic                           wr_req,
    input  logic                           wr_rdy,
    input  logic [31:0]                    wr_addr,
    input  logic [mem_bus_pkg::LINE_W-1:0] wr_data,
    output int                             err_count,
    output int                             reads_checked
);

    import cache_geom_pkg::*;
    import mem_bus_pkg::*;

    logic [31:0]      shadow_q [logic [31:0]];
    logic [TAG_W-1:0] res_tag   [NUM_SETS][NUM_WAYS];  // lines the cache should hold
    logic             res_valid [NUM_SETS][NUM_WAYS];
    logic             res_lru   [NUM_SETS];
    logic             pend;
    logic             pend_op;
    logic             pend_hit;
    logic [31:0]      pend_addr;
    logic [31:0]      pend_exp;
    int               latency;
    logic             rd_wait;    // rd_req seen without rd_rdy

    function automatic logic [31:0] shadow_word(input logic [31:0] a);
        if (shadow_q.exists({a[31:2], 2'b00})) begin
            return shadow_q[{a[31:2], 2'b00}];
        end
        return {a[31:2], 2'b00} ^ 32'h5a5a_a5a5;
    endfunction

    task automatic report_value(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        err_count++;
        $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
    endtask

    task automatic report_fault(input string what);
        err_count++;
        $display("at %0t: %s", $time, what);
    endtask

    task automatic apply_write(input logic [31:0] a, input logic [3:0] strb,
                               input logic [31:0] d);
        logic [31:0] word;
        word = shadow_word(a);
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                word[i*8 +: 8] = d[i*8 +: 8];
            end
        end
        shadow_q[{a[31:2], 2'b00}] = word;
    endtask

    // two-way lru residency decides hit or miss per request
    task automatic track_request(input cache_addr_t a);
        logic [INDEX_W-1:0] idx;
        logic               way;
        idx      = a.fields.index;
        way      = res_lru[idx];
        pend_hit = 1'b0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (res_valid[idx][w] && res_tag[idx][w] == a.fields.tag) begin
                pend_hit = 1'b1;
                way      = w[0];
            end
        end
        res_valid[idx][way] = 1'b1;
        res_tag[idx][way]   = a.fields.tag;
        res_lru[idx]        = ~way;
    endtask

    task automatic finish_request();
        if (!pend) begin
            report_fault("data_ok pulsed with no request outstanding");
        end else begin
            if (pend_hit && latency != 1) begin
                report_fault("hit did not answer one cycle after acceptance");
            end
            if (!pend_hit && latency == 1) begin
                report_fault("miss answered in hit time");
            end
            if (!pend_op) begin
                reads_checked++;
                if (rdata !== pend_exp) begin
                    report_value("rdata", pend_exp, rdata);
                end
                if (rdata !== shadow_word(pend_addr)) begin
                    report_value("rdata vs shadow", shadow_word(pend_addr), rdata);
                end
            end
            pend = 1'b0;
        end
    endtask

    initial begin
        err_count     = 0;
        reads_checked = 0;
        pend          = 1'b0;
        rd_wait       = 1'b0;
        latency       = 0;
        for (int s = 0; s < NUM_SETS; s++) begin
            res_lru[s] = 1'b0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                res_valid[s][w] = 1'b0;
                res_tag[s][w]   = '0;
            end
        end
    end

    always @(posedge clk) begin
        if (resetn) begin
            if (pend) begin
                latency++;
            end
            if (pend && addr_ok) begin
                report_fault("addr_ok high while a request is outstanding");
            end
            if (rd_wait && !rd_req) begin
                report_fault("rd_req dropped before rd_rdy was seen");
            end
            // refill starts at the base of the requested line
            if (rd_req && rd_rdy && rd_addr !== {pend_addr[31:4], 4'h0}) begin
                report_value("rd_addr", {pend_addr[31:4], 4'h0}, rd_addr);
            end
            if (wr_req && !wr_rdy) begin
                report_fault("wr_req raised while wr_rdy is low");
            end
            if (wr_req) begin    // written-back line must match shadow memory
                for (int b = 0; b < BEATS_PER_LINE; b++) begin
                    if (wr_data[b*32 +: 32] !== shadow_word(wr_addr + 32'(4*b))) begin
                        report_value($sformatf("wr_data[%0d]", b),
                                     shadow_word(wr_addr + 32'(4*b)), wr_data[b*32 +: 32]);
                    end
                end
            end
            if (data_ok) begin
                finish_request();
            end
            if (valid && addr_ok) begin
                pend      = 1'b1;
                pend_op   = op;
                pend_addr = addr.raw;
                pend_exp  = exp_rdata;
                latency   = 0;
                track_request(addr);
                if (op) begin
                    apply_write(addr.raw, wstrb, wdata);
                end
            end
            rd_wait = rd_req && !rd_rdy;
        end
    end

endmodule

// File: test/cache_tb.sv
`timescale 1ns/1ps

module cache_tb;

    import cache_geom_pkg::*;
    import mem_bus_pkg::*;

    localparam int MAX_VEC    = 64;
    localparam int VEC_FIELDS = 5;    // op, addr, wstrb, wdata, expected rdata

    logic              clk;
    logic              resetn;
    logic              valid;
    logic              op;
    cache_addr_t       addr;
    logic [3:0]        wstrb;
    logic [31:0]       wdata;
    logic [31:0]       exp_rdata;
    logic              addr_ok;
    logic              data_ok;
    logic [31:0]       rdata;
    logic              rd_req, rd_rdy, ret_valid, ret_last;
    logic [31:0]       rd_addr;
    logic [31:0]       ret_data;
    logic              wr_req, wr_rdy;
    logic [31:0]       wr_addr;
    logic [LINE_W-1:0] wr_data;

    logic [31:0] vec_mem [MAX_VEC*VEC_FIELDS];
    logic [31:0] mem_q [logic [31:0]];    // words written back by the cache
    integer      seed = 32'h016e_1b61;
    int          num_vec;
    int          cycle_cnt = 0;
    int          cycle_limit = 1000;
    int          err_count;
    int          reads_checked;

    cache_top u_cache_top (
        .clk, .resetn,
        .valid, .op, .addr, .wstrb, .wdata, .addr_ok, .data_ok, .rdata,
        .rd_req, .rd_addr, .rd_rdy, .ret_valid, .ret_last, .ret_data,
        .wr_req, .wr_addr, .wr_data, .wr_rdy
    );

    cache_checker u_checker (
        .clk, .resetn,
        .valid, .op, .addr, .wstrb, .wdata, .exp_rdata,
        .addr_ok, .data_ok, .rdata,
        .rd_req, .rd_rdy, .rd_addr, .wr_req, .wr_rdy, .wr_addr, .wr_data,
        .err_count, .reads_checked
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // untouched words hold a pattern of their own address
    function automatic logic [31:0] mem_word(input logic [31:0] a);
        if (mem_q.exists(a)) begin
            return mem_q[a];
        end
        return a ^ 32'h5a5a_a5a5;
    endfunction

    task automatic run_request(input int v);
        int base;
        base      = v * VEC_FIELDS;
        valid     = 1'b1;
        op        = vec_mem[base][0];
        addr      = vec_mem[base+1];
        wstrb     = vec_mem[base+2][3:0];
        wdata     = vec_mem[base+3];
        exp_rdata = vec_mem[base+4];
        @(posedge clk);
        while (!addr_ok) @(posedge clk);    // held until taken
        #1 valid = 1'b0;
        @(posedge clk);
        while (!data_ok) @(posedge clk);
        #1;
    endtask

    initial begin : stimulus
        valid     = 1'b0;
        op        = 1'b0;
        addr      = '0;
        wstrb     = '0;
        wdata     = '0;
        exp_rdata = '0;
        rd_rdy    = 1'b0;
        wr_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        resetn    = 1'b0;
        for (int i = 0; i < MAX_VEC * VEC_FIELDS; i++) begin
            vec_mem[i] = '1;    // all ones op marks the end
        end
        $readmemh("test/cache_vectors.hex", vec_mem);
        num_vec = 0;
        while (num_vec < MAX_VEC && vec_mem[num_vec*VEC_FIELDS] != '1) begin
            num_vec++;
        end
        if (num_vec == 0) begin
            $display("no requests were read from test/cache_vectors.hex");
        end
        cycle_limit = 200 * num_vec + 20;
        repeat (3) @(posedge clk);
        #1 resetn = 1'b1;
        for (int v = 0; v < num_vec; v++) begin
            run_request(v);
        end
        repeat (4) @(posedge clk);
        $display("%0d requests, %0d reads checked, %0d errors", num_vec, reads_checked, err_count);
        if (err_count == 0 && num_vec > 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // main memory with random stalls on both ready lines
    initial begin : memory_model
        logic [31:0] line_addr;
        forever begin
            @(posedge clk);
            if (wr_req) begin
                for (int b = 0; b < BEATS_PER_LINE; b++) begin
                    mem_q[wr_addr + 32'(4*b)] = wr_data[b*32 +: 32];
                end
            end
            if (rd_req && rd_rdy) begin
                line_addr = rd_addr;
                for (int b = 0; b < BEATS_PER_LINE; b++) begin    // bank 0 first
                    #1;
                    rd_rdy    = 1'b0;
                    ret_valid = 1'b1;
                    ret_last  = (b == BEATS_PER_LINE - 1);
                    ret_data  = mem_word(line_addr + 32'(4*b));
                    @(posedge clk);
                end
            end
            #1;
            ret_valid = 1'b0;
            ret_last  = 1'b0;
            rd_rdy    = ($random(seed) & 3) != 0;   // stalls about one cycle in four
            wr_rdy    = ($random(seed) & 3) != 0;
        end
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout after %0d cycles with requests still running", cycle_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

endmodule

// File: test/cache_vectors.hex
// each line holds op addr wstrb wdata expected_rdata in hex
// op 1 is a write and its expected word is not checked
// cold read misses then hits on the same line
0 00001010 0 00000000 5a5ab5b5
0 0000101c 0 00000000 5a5ab5b9
0 00001014 0 00000000 5a5ab5b1
0 00002028 0 00000000 5a5a858d
// partial write hit then read back
1 00001014 3 11223344 00000000
0 00001014 0 00000000 5a5a3344
// write miss allocates and merges
1 00003034 c aabbccdd 00000000
0 00003034 0 00000000 aabb9591
0 00003030 0 00000000 5a5a9595
// three tags in set 05 force dirty evictions
1 00000050 f deadbeef 00000000
1 00010054 f 0badf00d 00000000
0 00020058 0 00000000 5a58a5fd
0 00000050 0 00000000 deadbeef
0 00010054 0 00000000 0badf00d
0 00000050 0 00000000 deadbeef
0 00020058 0 00000000 5a58a5fd
// dirty line in set 03 with a hit write before eviction
1 00003030 1 00000077 00000000
0 00103030 0 00000000 5a4a9595
0 00203034 0 00000000 5a7a9591
0 00003034 0 00000000 aabb9591
0 00003030 0 00000000 5a5a9577
// set 01 still holds its written line
0 00001014 0 00000000 5a5a3344
0 00001018 0 00000000 5a5ab5bd
